// ==== compile.f ====
hdl/ppuPkg.sv
hdl/ppuRegisters.sv
hdl/lcdTiming.sv
hdl/vramArbiter.sv
hdl/bgRenderer.sv
hdl/ppu.sv
tests/ppu_props.sv
tests/ppuTb.sv

// ==== Bender.yml ====
package:
  name: ppu

sources:
  - hdl/ppuPkg.sv
  - hdl/ppuRegisters.sv
  - hdl/lcdTiming.sv
  - hdl/vramArbiter.sv
  - hdl/bgRenderer.sv
  - hdl/ppu.sv
  - target: test
    files:
      - tests/ppu_props.sv
      - tests/ppuTb.sv

// ==== tests/ppuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppuTb import ppuPkg::*; ();

   localparam int lineDots    = 456;
   localparam int scanDots    = 80;
   localparam int drawDots    = 172;
   localparam int frameCycles = 154 * lineDots;

   logic        clock = 1'b0;
   logic        arstN;
   logic [15:0] cpuAddr;
   logic [7:0]  cpuWdata;
   logic        cpuSel;
   logic        cpuWr;
   logic [7:0]  cpuRdata;
   logic [12:0] vramAddr;
   logic [7:0]  vramWdata;
   logic        vramWe;
   logic [7:0]  vramRdata;
   logic        lineReq;
   logic        lineAck;
   line_t       linePixels;
   logic [7:0]  lineNumber;
   logic        vblankIrq;
   logic        statIrq;
   logic [7:0]  ly;
   logic [7:0]  vram [0:8191];

   always #20 clock = ~clock;

   ppu dut (
      .clock      (clock),
      .arstN      (arstN),
      .cpuAddr    (cpuAddr),
      .cpuWdata   (cpuWdata),
      .cpuSel     (cpuSel),
      .cpuWr      (cpuWr),
      .cpuRdata   (cpuRdata),
      .vramAddr   (vramAddr),
      .vramWdata  (vramWdata),
      .vramWe     (vramWe),
      .vramRdata  (vramRdata),
      .lineReq    (lineReq),
      .lineAck    (lineAck),
      .linePixels (linePixels),
      .lineNumber (lineNumber),
      .vblankIrq  (vblankIrq),
      .statIrq    (statIrq),
      .ly         (ly)
   );

   // single port vram, read data one cycle after the address.
   always @(posedge clock) begin
      if (vramWe)
         vram[vramAddr] <= vramWdata;
      vramRdata <= vram[vramAddr];
   end

   // ------------------------------------------------------------
   // compare and reference helpers.
   // ------------------------------------------------------------
   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp)
         abortRun($sformatf("ERROR at %0t ns: %s: got %02h, expected %02h",
                            $time, what, got, exp));
   endtask

   task automatic checkMode(input lcdMode_t got, input lcdMode_t exp, input string what);
      if (got !== exp)
         abortRun($sformatf("ERROR at %0t ns: %s: got mode %0d, expected mode %0d",
                            $time, what, got, exp));
   endtask

   task automatic checkLine(input line_t got, input line_t exp, input string what);
      if (got !== exp)
         abortRun($sformatf("ERROR at %0t ns: %s: got %h, expected %h",
                            $time, what, got, exp));
   endtask

   function automatic line_t expectedLine(input int lineNo, input logic [7:0] control,
                                          input logic [7:0] palette);
      line_t      result;
      int         mapAddr;
      int         dataAddr;
      int         signedTile;
      int         colorIdx;
      logic [7:0] tileByte;
      logic [7:0] low;
      logic [7:0] high;
      for (int t = 0; t < 20; t++) begin
         mapAddr  = (control[3] ? 7168 : 6144) + 32 * (lineNo / 8) + t;
         tileByte = vram[mapAddr];
         if (control[4]) begin
            dataAddr = 16 * tileByte;
         end else begin
            signedTile = $signed(tileByte);
            dataAddr   = 4096 + 16 * signedTile;
         end
         dataAddr = dataAddr + 2 * (lineNo % 8);
         low      = vram[dataAddr];
         high     = vram[dataAddr + 1];
         // leftmost pixel from bit 7.
         for (int px = 0; px < 8; px++) begin
            colorIdx           = {high[7 - px], low[7 - px]};
            result[t * 8 + px] = palette[2 * colorIdx +: 2];
         end
      end
      return result;
   endfunction

   // ------------------------------------------------------------
   // bus and wait tasks.
   // ------------------------------------------------------------
   task automatic nextCycle();
      @(posedge clock);
      #2;
   endtask

   task automatic writeReg(input logic [15:0] addr, input logic [7:0] data);
      nextCycle();
      cpuAddr  = addr;
      cpuWdata = data;
      cpuSel   = 1'b1;
      cpuWr    = 1'b1;
      nextCycle();
      cpuSel   = 1'b0;
      cpuWr    = 1'b0;
   endtask

   task automatic readBus(input logic [15:0] addr, output logic [7:0] data);
      nextCycle();
      cpuAddr = addr;
      cpuSel  = 1'b1;
      @(posedge clock);
      @(negedge clock);
      data = cpuRdata;
   endtask

   task automatic waitMode(input lcdMode_t target);
      int count;
      nextCycle();
      cpuAddr = regStat;
      count   = 0;
      do begin
         @(negedge clock);
         count++;
         if (count > frameCycles)
            abortRun("timed out waiting for an LCD mode in STAT");
      end while (lcdMode_t'(cpuRdata[1:0]) != target);
   endtask

   task automatic waitLy(input logic [7:0] target);
      int count;
      count = 0;
      do begin
         @(negedge clock);
         count++;
         if (count > frameCycles)
            abortRun("timed out waiting for LY to reach a line");
      end while (ly != target);
   endtask

   task automatic waitLineReq();
      int count;
      count = 0;
      do begin
         @(negedge clock);
         count++;
         if (count > frameCycles)
            abortRun("timed out waiting for lineReq");
      end while (!lineReq);
   endtask

   task automatic ackLine();
      int count;
      nextCycle();
      lineAck = 1'b1;
      count   = 0;
      do begin
         @(negedge clock);
         count++;
         if (count > 16)
            abortRun("lineReq did not drop after lineAck");
      end while (lineReq);
      nextCycle();
      lineAck = 1'b0;
   endtask

   // lcd off, then close any handoff left open.
   task automatic shutDown();
      writeReg(regLcdc, 8'h00);
      nextCycle();
      nextCycle();
      if (lineReq)
         ackLine();
   endtask

   // ------------------------------------------------------------
   // directed tests.
   // ------------------------------------------------------------
   task automatic testRegisters();
      logic [7:0] value;
      logic [7:0] got;
      value = 8'($urandom) & 8'h7F;
      writeReg(regLcdc, value);
      readBus(regLcdc, got);
      checkByte(got, value, "LCDC readback");
      writeReg(regLcdc, 8'h00);
      value = 8'($urandom) | 8'h01;
      writeReg(regLyc, value);
      readBus(regLyc, got);
      checkByte(got, value, "LYC readback");
      value = 8'($urandom);
      writeReg(regBgp, value);
      readBus(regBgp, got);
      checkByte(got, value, "BGP readback");
      writeReg(regLy, 8'h5A);
      readBus(regLy, got);
      checkByte(got, 8'h00, "LY after a write");
      // enables 6 and 4, lcd off so hBlank.
      writeReg(regStat, 8'h50);
      readBus(regStat, got);
      checkByte(got, 8'hD0, "STAT without coincidence");
      writeReg(regLyc, 8'h00);
      readBus(regStat, got);
      checkByte(got, 8'hD4, "STAT with coincidence");
      readBus(16'hFF42, got);
      checkByte(got, 8'hFF, "unmapped register");
      writeReg(regStat, 8'h00);
   endtask

   task automatic testTiming();
      lcdMode_t expMode;
      writeReg(regLcdc, 8'h80);
      cpuAddr = regStat;
      for (int d = 0; d <= lineDots; d++) begin
         @(negedge clock);
         if (d < scanDots || d == lineDots)
            expMode = oamScan;
         else if (d < scanDots + drawDots)
            expMode = drawing;
         else
            expMode = hBlank;
         checkMode(lcdMode_t'(cpuRdata[1:0]), expMode, "STAT mode");
         checkByte(ly, (d < lineDots) ? 8'd0 : 8'd1, "LY count");
      end
      shutDown();
   endtask

   task automatic testInterrupts();
      logic [7:0] lycValue;
      int         refLine;
      lycValue = 8'($urandom % 154);
      writeReg(regLyc, lycValue);
      writeReg(regStat, 8'h40);
      writeReg(regLcdc, 8'h80);
      // n counts dots from the first enabled cycle, a frame and a line.
      for (int n = 0; n < frameCycles + lineDots; n++) begin
         @(negedge clock);
         refLine = (n / lineDots) % 154;
         checkByte(ly, 8'(refLine), "LY over a frame");
         checkByte({7'd0, vblankIrq}, {7'd0, n == 144 * lineDots}, "vblankIrq pulse");
         checkByte({7'd0, statIrq}, {7'd0, refLine == lycValue}, "statIrq on LY match");
      end
      writeReg(regStat, 8'h00);
      shutDown();
   endtask

   task automatic testRender();
      logic [7:0] control;
      logic [7:0] palette;
      for (int cfg = 0; cfg < 4; cfg++) begin
         // bit 3 picks the map, bit 4 the tile addressing.
         control = 8'h80 | 8'(cfg << 3);
         palette = 8'($urandom);
         writeReg(regBgp, palette);
         writeReg(regLcdc, control);
         for (int k = 0; k < 10; k++) begin
            waitLineReq();
            checkByte(lineNumber, 8'(k), "lineNumber");
            checkLine(linePixels, expectedLine(k, control, palette), "rendered line");
            ackLine();
         end
         shutDown();
      end
   endtask

   task automatic testLockout();
      logic [12:0] offset;
      logic [7:0]  original;
      logic [7:0]  got;
      offset   = 13'($urandom % 'h1800);
      original = vram[offset];
      writeReg(regLcdc, 8'h90);
      waitMode(oamScan);
      waitMode(drawing);
      readBus(vramBase + offset, got);
      checkByte(got, 8'hFF, "VRAM read in drawing");
      writeReg(vramBase + offset, ~original);
      checkByte(vram[offset], original, "VRAM after a write in drawing");
      waitMode(hBlank);
      readBus(vramBase + offset, got);
      checkByte(got, original, "VRAM read in hBlank");
      writeReg(vramBase + offset, ~original);
      checkByte(vram[offset], ~original, "VRAM after a write in hBlank");
      readBus(vramBase + offset, got);
      checkByte(got, ~original, "VRAM readback in hBlank");
      shutDown();
   endtask

   task automatic testBackPressure();
      logic [7:0] palette;
      palette = 8'($urandom);
      writeReg(regBgp, palette);
      writeReg(regLcdc, 8'h90);
      waitLineReq();
      checkByte(lineNumber, 8'd0, "first lineNumber");
      // request still open when line 1 starts drawing, so that line is dropped.
      waitLy(8'd1);
      waitMode(drawing);
      ackLine();
      waitLineReq();
      checkByte(lineNumber, 8'd2, "lineNumber after the skipped line");
      checkLine(linePixels, expectedLine(2, 8'h90, palette), "line after the skip");
      ackLine();
      shutDown();
   endtask

   initial begin
      int seedValue;
      seedValue = 32'h6362;
      void'($urandom(seedValue));
      arstN     = 1'b0;
      cpuAddr   = 16'h0000;
      cpuWdata  = 8'h00;
      cpuSel    = 1'b0;
      cpuWr     = 1'b0;
      lineAck   = 1'b0;
      vramRdata = 8'h00;
      for (int a = 0; a < 8192; a++)
         vram[a] = 8'($urandom);
      repeat (5) @(posedge clock);
      #2;
      arstN = 1'b1;

      testRegisters();
      testTiming();
      testInterrupts();
      testRender();
      testLockout();
      testBackPressure();

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/ppu_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppuProps import ppuPkg::*; (
   input  wire             clock,
   input  wire             arstN,
   input  wire             lineReq,
   input  wire             lineAck,
   input  wire             vramWe,
   input  wire  lcdMode_t  mode
);

   // an open request stays up until the ack arrives.
   reqHeld: assert property (@(posedge clock) disable iff (!arstN)
      lineReq && !lineAck |=> lineReq)
      else $error("lineReq dropped before lineAck was seen");

   noReqDuringAck: assert property (@(posedge clock) disable iff (!arstN)
      !lineReq && lineAck |=> !lineReq)
      else $error("lineReq rose while lineAck was still high");

   // renderer owns the port in drawing.
   noWriteInDraw: assert property (@(posedge clock) disable iff (!arstN)
      mode == drawing |-> !vramWe)
      else $error("VRAM write enable seen during drawing");

endmodule

bind ppu ppuProps props (
   .clock   (clock),
   .arstN   (arstN),
   .lineReq (lineReq),
   .lineAck (lineAck),
   .vramWe  (vramWe),
   .mode    (mode)
);

`default_nettype wire

// ==== hdl/ppu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu import ppuPkg::*; #(
   parameter int dotsPerLine  = 456,
   parameter int oamDots      = 80,
   parameter int drawDots     = 172,
   parameter int visibleLines = 144,
   parameter int totalLines   = 154
) (
   input  wire                       clock,
   input  wire                       arstN,

   input  wire  [15:0]               cpuAddr,
   input  wire  [7:0]                cpuWdata,
   input  wire                       cpuSel,
   input  wire                       cpuWr,
   output logic [7:0]                cpuRdata,

   output logic [vramAddrWidth-1:0]  vramAddr,
   output logic [7:0]                vramWdata,
   output logic                      vramWe,
   input  wire  [7:0]                vramRdata,

   output logic                      lineReq,
   input  wire                       lineAck,
   output line_t                     linePixels,
   output logic [7:0]                lineNumber,

   output logic                      vblankIrq,
   output logic                      statIrq,
   output logic [7:0]                ly
);

   logic [7:0]               lcdc;
   logic [3:0]               statEnable;
   logic [7:0]               lyc;
   logic [7:0]               bgp;
   logic [7:0]               regRdata;
   lcdMode_t                 mode;
   logic                     lyMatch;
   logic [vramAddrWidth-1:0] renderAddr;

   ppuRegisters registers (
      .clock      (clock),
      .arstN      (arstN),
      .cpuAddr    (cpuAddr),
      .cpuWdata   (cpuWdata),
      .cpuSel     (cpuSel),
      .cpuWr      (cpuWr),
      .ly         (ly),
      .mode       (mode),
      .lyMatch    (lyMatch),
      .lcdc       (lcdc),
      .statEnable (statEnable),
      .lyc        (lyc),
      .bgp        (bgp),
      .regRdata   (regRdata)
   );

   lcdTiming #(
      .dotsPerLine  (dotsPerLine),
      .oamDots      (oamDots),
      .drawDots     (drawDots),
      .visibleLines (visibleLines),
      .totalLines   (totalLines)
   ) timing (
      .clock      (clock),
      .arstN      (arstN),
      .lcdEnable  (lcdc[7]),
      .lyc        (lyc),
      .statEnable (statEnable),
      .ly         (ly),
      .mode       (mode),
      .lyMatch    (lyMatch),
      .vblankIrq  (vblankIrq),
      .statIrq    (statIrq)
   );

   vramArbiter arbiter (
      .cpuAddr    (cpuAddr),
      .cpuWdata   (cpuWdata),
      .cpuSel     (cpuSel),
      .cpuWr      (cpuWr),
      .mode       (mode),
      .regRdata   (regRdata),
      .renderAddr (renderAddr),
      .vramRdata  (vramRdata),
      .vramAddr   (vramAddr),
      .vramWdata  (vramWdata),
      .vramWe     (vramWe),
      .cpuRdata   (cpuRdata)
   );

   bgRenderer renderer (
      .clock      (clock),
      .arstN      (arstN),
      .mode       (mode),
      .ly         (ly),
      .lcdc       (lcdc),
      .bgp        (bgp),
      .vramRdata  (vramRdata),
      .renderAddr (renderAddr),
      .lineReq    (lineReq),
      .linePixels (linePixels),
      .lineNumber (lineNumber),
      .lineAck    (lineAck)
   );

endmodule

`default_nettype wire

// ==== hdl/bgRenderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bgRenderer import ppuPkg::*; (
   input  wire                       clock,
   input  wire                       arstN,

   input  wire  lcdMode_t            mode,
   input  wire  [7:0]                ly,
   input  wire  [7:0]                lcdc,
   input  wire  [7:0]                bgp,
   input  wire  [7:0]                vramRdata,

   output logic [vramAddrWidth-1:0]  renderAddr,

   output logic                      lineReq,
   output line_t                     linePixels,
   output logic [7:0]                lineNumber,
   input  wire                       lineAck
);

   localparam logic [4:0] lineTiles = 5'(tilesPerLine);

   logic                      wasDrawing;
   logic                      drawStart;
   logic                      hBlankStart;
   logic                      keepLine;
   logic                      raiseReq;
   logic [1:0]                phase;
   logic [4:0]                tileIdx;
   logic [7:0]                tileNum;
   logic [7:0]                lowPlane;
   logic [7:0]                curTile;
   logic [vramAddrWidth-1:0]  mapAddr;
   logic [vramAddrWidth-1:0]  tileBase;
   logic [7:0][1:0]           tileShades;

   assign drawStart   = (mode == drawing) && !wasDrawing;
   assign hBlankStart = (mode == hBlank) && wasDrawing;

   // ------------------------------------------------------------
   // fetch addresses.
   // ------------------------------------------------------------
   assign mapAddr = (lcdc[3] ? mapBase1 : mapBase0)
                  + vramAddrWidth'(mapRowStride) * vramAddrWidth'(ly[7:3])
                  + vramAddrWidth'(tileIdx);

   // map data arrives in phase 1, so use it straight from the bus.
   assign curTile = (phase == 2'd1) ? vramRdata : tileNum;

   // lcdc bit 4 clear means signed tile numbers around 0x1000.
   assign tileBase = lcdc[4] ? {1'b0, curTile, 4'b0000}
                             : signedDataBase + {curTile[7], curTile, 4'b0000};

   always_comb begin
      case (phase)
         2'd1:    renderAddr = tileBase + vramAddrWidth'({ly[2:0], 1'b0});
         2'd2:    renderAddr = tileBase + vramAddrWidth'({ly[2:0], 1'b1});
         default: renderAddr = mapAddr;
      endcase
   end

   // high plane is on the bus in phase 3. leftmost pixel is bit 7.
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         tileShades[i] = bgp[2 * {vramRdata[7 - i], lowPlane[7 - i]} +: 2];
      end
   end

   // ------------------------------------------------------------
   // tile sequencing and line handshake.
   // ------------------------------------------------------------
   assign raiseReq = hBlankStart && keepLine && (tileIdx == lineTiles) && !lineAck;

   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         wasDrawing <= 1'b0;
         keepLine   <= 1'b0;
         phase      <= 2'd0;
         tileIdx    <= 5'd0;
         lineReq    <= 1'b0;
      end else begin
         wasDrawing <= (mode == drawing);

         // skip the line if the last handoff has not closed.
         if (drawStart)
            keepLine <= !(lineReq || lineAck);

         if (mode != drawing) begin
            phase   <= 2'd0;
            tileIdx <= 5'd0;
         end else if (tileIdx != lineTiles) begin
            phase <= phase + 2'd1;
            if (phase == 2'd3)
               tileIdx <= tileIdx + 5'd1;
         end

         if (lineReq && lineAck)
            lineReq <= 1'b0;
         else if (raiseReq)
            lineReq <= 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (mode == drawing) begin
         if (phase == 2'd1)
            tileNum <= vramRdata;
         if (phase == 2'd2)
            lowPlane <= vramRdata;
         if (phase == 2'd3 && keepLine)
            linePixels[{tileIdx, 3'b000} +: 8] <= tileShades;
      end
      if (raiseReq)
         lineNumber <= ly;
   end

endmodule

`default_nettype wire

// ==== hdl/vramArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module vramArbiter import ppuPkg::*; (
   input  wire  [15:0]               cpuAddr,
   input  wire  [7:0]                cpuWdata,
   input  wire                       cpuSel,
   input  wire                       cpuWr,
   input  wire  lcdMode_t            mode,
   input  wire  [7:0]                regRdata,
   input  wire  [vramAddrWidth-1:0]  renderAddr,
   input  wire  [7:0]                vramRdata,

   output logic [vramAddrWidth-1:0]  vramAddr,
   output logic [7:0]                vramWdata,
   output logic                      vramWe,
   output logic [7:0]                cpuRdata
);

   logic inWindow;
   logic renderOwns;

   assign inWindow   = (cpuAddr >= vramBase) && (cpuAddr <= vramTop);
   assign renderOwns = (mode == drawing);

   // renderer owns the port for the whole drawing phase.
   assign vramAddr  = renderOwns ? renderAddr
                                 : vramAddrWidth'(cpuAddr - vramBase);
   assign vramWdata = cpuWdata;
   assign vramWe    = !renderOwns && cpuSel && cpuWr && inWindow;

   always_comb begin
      if (!inWindow)
         cpuRdata = regRdata;
      else if (renderOwns)
         cpuRdata = 8'hFF;
      else
         cpuRdata = vramRdata;
   end

endmodule

`default_nettype wire

// ==== hdl/lcdTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcdTiming import ppuPkg::*; #(
   parameter int dotsPerLine  = 456,
   parameter int oamDots      = 80,
   parameter int drawDots     = 172,
   parameter int visibleLines = 144,
   parameter int totalLines   = 154
) (
   input  wire             clock,
   input  wire             arstN,

   input  wire             lcdEnable,
   input  wire  [7:0]      lyc,
   input  wire  [3:0]      statEnable,

   output logic [7:0]      ly,
   output lcdMode_t        mode,
   output logic            lyMatch,
   output logic            vblankIrq,
   output logic            statIrq
);

   localparam int dotWidth = $clog2(dotsPerLine);

   localparam logic [dotWidth-1:0] lastDot   = dotWidth'(dotsPerLine - 1);
   localparam logic [dotWidth-1:0] drawFirst = dotWidth'(oamDots);
   localparam logic [dotWidth-1:0] drawAfter = dotWidth'(oamDots + drawDots);

   localparam logic [7:0] lastVisibleLine = 8'(visibleLines - 1);
   localparam logic [7:0] firstBlankLine  = 8'(visibleLines);
   localparam logic [7:0] lastLine        = 8'(totalLines - 1);

   logic [dotWidth-1:0] dot;
   logic                endOfLine;

   assign endOfLine = (dot == lastDot);

   // ------------------------------------------------------------
   // dot and line counters.
   // ------------------------------------------------------------
   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         dot <= '0;
         ly  <= 8'd0;
      end else if (!lcdEnable) begin
         dot <= '0;
         ly  <= 8'd0;
      end else if (endOfLine) begin
         dot <= '0;
         ly  <= (ly == lastLine) ? 8'd0 : ly + 8'd1;
      end else begin
         dot <= dot + 1'b1;
      end
   end

   always_comb begin
      if (!lcdEnable)
         mode = hBlank;
      else if (ly >= firstBlankLine)
         mode = vBlank;
      else if (dot < drawFirst)
         mode = oamScan;
      else if (dot < drawAfter)
         mode = drawing;
      else
         mode = hBlank;
   end

   // ------------------------------------------------------------
   // interrupts.
   // ------------------------------------------------------------
   assign lyMatch = (ly == lyc);

   // high on dot 0 of the first vblank line.
   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN)
         vblankIrq <= 1'b0;
      else
         vblankIrq <= lcdEnable && endOfLine && (ly == lastVisibleLine);
   end

   assign statIrq = (statEnable[0] && (mode == hBlank))
                 || (statEnable[1] && (mode == vBlank))
                 || (statEnable[2] && (mode == oamScan))
                 || (statEnable[3] && lyMatch);

endmodule

`default_nettype wire

// ==== hdl/ppuRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppuRegisters import ppuPkg::*; (
   input  wire             clock,
   input  wire             arstN,

   input  wire  [15:0]     cpuAddr,
   input  wire  [7:0]      cpuWdata,
   input  wire             cpuSel,
   input  wire             cpuWr,

   input  wire  [7:0]      ly,
   input  wire  lcdMode_t  mode,
   input  wire             lyMatch,

   output logic [7:0]      lcdc,
   output logic [3:0]      statEnable,
   output logic [7:0]      lyc,
   output logic [7:0]      bgp,

   output logic [7:0]      regRdata
);

   logic regWrite;

   assign regWrite = cpuSel && cpuWr;

   // ------------------------------------------------------------
   // write decode.
   // ------------------------------------------------------------
   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         lcdc       <= 8'h00;
         statEnable <= 4'h0;
         lyc        <= 8'h00;
         bgp        <= 8'h00;
      end else if (regWrite) begin
         case (cpuAddr)
            regLcdc: lcdc       <= cpuWdata;
            // only the interrupt enables are writable.
            regStat: statEnable <= cpuWdata[6:3];
            regLyc:  lyc        <= cpuWdata;
            regBgp:  bgp        <= cpuWdata;
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------
   // read mux.
   // ------------------------------------------------------------
   always_comb begin
      case (cpuAddr)
         regLcdc: regRdata = lcdc;
         regStat: regRdata = {1'b1, statEnable, lyMatch, mode};
         regLy:   regRdata = ly;
         regLyc:  regRdata = lyc;
         regBgp:  regRdata = bgp;
         default: regRdata = 8'hFF;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/ppuPkg.sv ====
`default_nettype none

package ppuPkg;

   // ------------------------------------------------------------
   // lcd mode, as it reads in STAT bits 1:0.
   // ------------------------------------------------------------
   typedef enum logic [1:0] {
      hBlank  = 2'd0,
      vBlank  = 2'd1,
      oamScan = 2'd2,
      drawing = 2'd3
   } lcdMode_t;

   // ------------------------------------------------------------
   // cpu register map.
   // ------------------------------------------------------------
   localparam logic [15:0] regLcdc = 16'hFF40;
   localparam logic [15:0] regStat = 16'hFF41;
   localparam logic [15:0] regLy   = 16'hFF44;
   localparam logic [15:0] regLyc  = 16'hFF45;
   localparam logic [15:0] regBgp  = 16'hFF47;

   // cpu window onto video ram.
   localparam logic [15:0] vramBase = 16'h8000;
   localparam logic [15:0] vramTop  = 16'h9FFF;

   localparam int vramAddrWidth = 13;

   // screen geometry.
   localparam int screenWidth  = 160;
   localparam int tilesPerLine = 20;
   localparam int mapRowStride = 32;

   // tile map and tile data offsets inside video ram.
   localparam logic [vramAddrWidth-1:0] mapBase0       = 13'h1800;
   localparam logic [vramAddrWidth-1:0] mapBase1       = 13'h1C00;
   localparam logic [vramAddrWidth-1:0] signedDataBase = 13'h1000;

   // one shade per pixel, pixel 0 in the low bits.
   typedef logic [screenWidth-1:0][1:0] line_t;

endpackage

`default_nettype wire
